//--- verilog/control_pkg.sv
package control_pkg;

    // microword layout
    localparam int INSTR_WIDTH = 24;
    localparam int CTRL_HI = 23;
    localparam int CTRL_LO = 21;
    localparam int TARG_HI = 20;
    localparam int TARG_LO = 16;
    localparam int LDEV_HI = 12;
    localparam int LDEV_LO = 9;
    localparam int RDEV_HI = 8;
    localparam int RDEV_LO = 5;
    localparam int ALUOP_HI = 4;
    localparam int ALUOP_LO = 0;

    localparam int CTRL_WIDTH = CTRL_HI - CTRL_LO + 1;
    localparam int TDEV_WIDTH = TARG_HI - TARG_LO + 1;
    localparam int DEV_WIDTH = LDEV_HI - LDEV_LO + 1;

    localparam int PC_WIDTH = 16;
    localparam int RAM_DEPTH = 256;
    localparam int RAM_ADDR_WIDTH = 8;

    // opcode classes
    localparam logic [CTRL_WIDTH-1:0] OP_ALU        = 3'd0;
    localparam logic [CTRL_WIDTH-1:0] OP_CONST8     = 3'd1;
    localparam logic [CTRL_WIDTH-1:0] OP_NOP2       = 3'd2; // no 16-bit load here
    localparam logic [CTRL_WIDTH-1:0] OP_NOP3       = 3'd3;
    localparam logic [CTRL_WIDTH-1:0] OP_ROM_DIRECT = 3'd4;
    localparam logic [CTRL_WIDTH-1:0] OP_RAM_DIRECT = 3'd5;
    localparam logic [CTRL_WIDTH-1:0] OP_STORE_RAM  = 3'd6;
    localparam logic [CTRL_WIDTH-1:0] OP_NOP7       = 3'd7;

    // bus sources, 8..15 read as zero
    localparam logic [DEV_WIDTH-1:0] DEV_REG_A   = 4'd0;
    localparam logic [DEV_WIDTH-1:0] DEV_REG_B   = 4'd1;
    localparam logic [DEV_WIDTH-1:0] DEV_REG_C   = 4'd2;
    localparam logic [DEV_WIDTH-1:0] DEV_REG_D   = 4'd3;
    localparam logic [DEV_WIDTH-1:0] DEV_RAM     = 4'd4;
    localparam logic [DEV_WIDTH-1:0] DEV_ROM     = 4'd5;
    localparam logic [DEV_WIDTH-1:0] DEV_INSTREG = 4'd6;
    localparam logic [DEV_WIDTH-1:0] DEV_ZERO    = 4'd7;

    // write targets
    localparam logic [TDEV_WIDTH-1:0] TDEV_REG_A = 5'd0;
    localparam logic [TDEV_WIDTH-1:0] TDEV_REG_B = 5'd1;
    localparam logic [TDEV_WIDTH-1:0] TDEV_REG_C = 5'd2;
    localparam logic [TDEV_WIDTH-1:0] TDEV_REG_D = 5'd3;
    localparam logic [TDEV_WIDTH-1:0] TDEV_RAM   = 5'd4;
    localparam logic [TDEV_WIDTH-1:0] TDEV_PC    = 5'd5;
    localparam logic [TDEV_WIDTH-1:0] TDEV_OUT   = 5'd6;
    localparam logic [TDEV_WIDTH-1:0] TDEV_HALT  = 5'd7;
    localparam logic [TDEV_WIDTH-1:0] TDEV_NONE  = 5'd31;

endpackage : control_pkg

//--- verilog/alu_pkg.sv
package alu_pkg;

    localparam int DATA_WIDTH = 8;
    localparam int ALUOP_WIDTH = 5;

    // operation codes, 10..31 give zero
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_PASSA = 5'd0;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_PASSB = 5'd1;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_ADD   = 5'd2;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_SUB   = 5'd3;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_AND   = 5'd4;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_OR    = 5'd5;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_XOR   = 5'd6;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_NOTA  = 5'd7;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_SHL   = 5'd8;
    localparam logic [ALUOP_WIDTH-1:0] ALUOP_SHR   = 5'd9;

endpackage : alu_pkg

//--- verilog/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    logic [control_pkg::TDEV_WIDTH-1:0] targ_dev;
    logic [control_pkg::DEV_WIDTH-1:0] lbus_dev;
    logic [control_pkg::DEV_WIDTH-1:0] rbus_dev;
    logic [alu_pkg::ALUOP_WIDTH-1:0] alu_op;

    modport decoder (
        output targ_dev, lbus_dev, rbus_dev, alu_op
    );

    modport datapath (
        input targ_dev, lbus_dev, rbus_dev, alu_op
    );

    // sequencer only cares about pc, out and halt targets
    modport control (
        input targ_dev
    );

endinterface : decode_if

//--- verilog/op_decoder.sv
`timescale 1ns/1ps

module op_decoder (
    input logic [control_pkg::INSTR_WIDTH-1:0] instr,
    decode_if.decoder dec
);

    logic [control_pkg::CTRL_WIDTH-1:0] ctrl;
    logic [control_pkg::TDEV_WIDTH-1:0] instr_targ;
    logic [control_pkg::DEV_WIDTH-1:0] instr_ldev;
    logic [control_pkg::DEV_WIDTH-1:0] instr_rdev;
    logic [control_pkg::DEV_WIDTH-1:0] store_src;
    logic [alu_pkg::ALUOP_WIDTH-1:0] instr_aluop;

    // field split
    assign ctrl        = instr[control_pkg::CTRL_HI:control_pkg::CTRL_LO];
    assign instr_targ  = instr[control_pkg::TARG_HI:control_pkg::TARG_LO];
    assign instr_ldev  = instr[control_pkg::LDEV_HI:control_pkg::LDEV_LO];
    assign instr_rdev  = instr[control_pkg::RDEV_HI:control_pkg::RDEV_LO];
    assign instr_aluop = instr[control_pkg::ALUOP_HI:control_pkg::ALUOP_LO];

    // store reuses the low bits of the target field as source register
    assign store_src = instr[control_pkg::TARG_LO+control_pkg::DEV_WIDTH-1:control_pkg::TARG_LO];

    always_comb begin
        // no-op selection unless a class overrides it
        dec.targ_dev = control_pkg::TDEV_NONE;
        dec.lbus_dev = control_pkg::DEV_ZERO;
        dec.rbus_dev = control_pkg::DEV_ZERO;
        dec.alu_op   = alu_pkg::ALUOP_PASSA;

        case (ctrl)
            control_pkg::OP_ALU: begin
                dec.targ_dev = instr_targ;
                dec.lbus_dev = instr_ldev;
                dec.rbus_dev = instr_rdev;
                dec.alu_op   = instr_aluop;
            end
            control_pkg::OP_CONST8: begin
                dec.targ_dev = instr_targ;
                dec.rbus_dev = control_pkg::DEV_INSTREG; // immediate byte
                dec.alu_op   = alu_pkg::ALUOP_PASSB;
            end
            control_pkg::OP_ROM_DIRECT: begin
                dec.targ_dev = instr_targ;
                dec.rbus_dev = control_pkg::DEV_ROM;
                dec.alu_op   = alu_pkg::ALUOP_PASSB;
            end
            control_pkg::OP_RAM_DIRECT: begin
                dec.targ_dev = instr_targ;
                dec.rbus_dev = control_pkg::DEV_RAM;
                dec.alu_op   = alu_pkg::ALUOP_PASSB;
            end
            control_pkg::OP_STORE_RAM: begin
                dec.targ_dev = control_pkg::TDEV_RAM; // target forced
                dec.lbus_dev = store_src;
            end
            control_pkg::OP_NOP2,
            control_pkg::OP_NOP3,
            control_pkg::OP_NOP7: begin
                dec.targ_dev = control_pkg::TDEV_NONE;
            end
            default: begin
                dec.targ_dev = control_pkg::TDEV_NONE;
            end
        endcase
    end

endmodule : op_decoder

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [alu_pkg::DATA_WIDTH-1:0] a,
    input  logic [alu_pkg::DATA_WIDTH-1:0] b,
    input  logic [alu_pkg::ALUOP_WIDTH-1:0] op,
    output logic [alu_pkg::DATA_WIDTH-1:0] result
);

    always_comb begin
        case (op)
            alu_pkg::ALUOP_PASSA: begin
                result = a;
            end
            alu_pkg::ALUOP_PASSB: begin
                result = b;
            end
            alu_pkg::ALUOP_ADD: begin
                result = a + b; // carry dropped, no flags
            end
            alu_pkg::ALUOP_SUB: begin
                result = a - b;
            end
            alu_pkg::ALUOP_AND: begin
                result = a & b;
            end
            alu_pkg::ALUOP_OR: begin
                result = a | b;
            end
            alu_pkg::ALUOP_XOR: begin
                result = a ^ b;
            end
            alu_pkg::ALUOP_NOTA: begin
                result = ~a;
            end
            alu_pkg::ALUOP_SHL: begin
                result = {a[alu_pkg::DATA_WIDTH-2:0], 1'b0};
            end
            alu_pkg::ALUOP_SHR: begin
                result = {1'b0, a[alu_pkg::DATA_WIDTH-1:1]};
            end
            default: begin
                result = '0; // unassigned codes
            end
        endcase
    end

endmodule : alu

//--- verilog/device_bank.sv
`timescale 1ns/1ps

module device_bank (
    input  logic clk,
    input  logic arst_n,
    decode_if.datapath dec,
    input  logic [control_pkg::INSTR_WIDTH-1:0] instr,
    input  logic [alu_pkg::DATA_WIDTH-1:0] rom_operand,
    input  logic write_en,
    output logic [alu_pkg::DATA_WIDTH-1:0] alu_result
);

    logic [alu_pkg::DATA_WIDTH-1:0] regs [4];
    logic [alu_pkg::DATA_WIDTH-1:0] ram [control_pkg::RAM_DEPTH];
    logic [control_pkg::RAM_ADDR_WIDTH-1:0] ram_addr;
    logic [alu_pkg::DATA_WIDTH-1:0] ram_rdata;
    logic [alu_pkg::DATA_WIDTH-1:0] lbus;
    logic [alu_pkg::DATA_WIDTH-1:0] rbus;

    assign ram_addr  = instr[control_pkg::RAM_ADDR_WIDTH-1:0];
    assign ram_rdata = ram[ram_addr]; // async read

    // same source decode for both buses
    function automatic logic [alu_pkg::DATA_WIDTH-1:0] bus_src(
        input logic [control_pkg::DEV_WIDTH-1:0] dev
    );
        case (dev)
            control_pkg::DEV_REG_A:   return regs[0];
            control_pkg::DEV_REG_B:   return regs[1];
            control_pkg::DEV_REG_C:   return regs[2];
            control_pkg::DEV_REG_D:   return regs[3];
            control_pkg::DEV_RAM:     return ram_rdata;
            control_pkg::DEV_ROM:     return rom_operand;
            control_pkg::DEV_INSTREG: return instr[alu_pkg::DATA_WIDTH-1:0];
            control_pkg::DEV_ZERO:    return '0;
            default:                  return '0;
        endcase
    endfunction

    always_comb begin
        lbus = bus_src(dec.lbus_dev);
        rbus = bus_src(dec.rbus_dev);
    end

    alu u_alu (
        .a      (lbus),
        .b      (rbus),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (write_en) begin
            case (dec.targ_dev)
                control_pkg::TDEV_REG_A: regs[0] <= alu_result;
                control_pkg::TDEV_REG_B: regs[1] <= alu_result;
                control_pkg::TDEV_REG_C: regs[2] <= alu_result;
                control_pkg::TDEV_REG_D: regs[3] <= alu_result;
                default: ; // not a register target
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_en && dec.targ_dev == control_pkg::TDEV_RAM) begin
            ram[ram_addr] <= alu_result;
        end
    end

endmodule : device_bank

//--- verilog/sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic clk,
    input  logic arst_n,
    decode_if.control dec,
    input  logic [control_pkg::INSTR_WIDTH-1:0] wb_dat_i,
    input  logic wb_ack,
    input  logic [alu_pkg::DATA_WIDTH-1:0] alu_result,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output logic [control_pkg::PC_WIDTH-1:0] wb_adr,
    output logic [control_pkg::INSTR_WIDTH-1:0] instr,
    output logic [alu_pkg::DATA_WIDTH-1:0] rom_operand,
    output logic write_en,
    output logic [alu_pkg::DATA_WIDTH-1:0] out_data,
    output logic out_valid,
    output logic halted
);

    typedef enum logic [1:0] {
        FETCH,
        OPERAND,
        WRITE,
        HALT
    } state_t;

    state_t state;
    state_t state_nxt;
    logic [control_pkg::PC_WIDTH-1:0] pc;
    logic bus_done;
    logic need_operand;

    assign bus_done = wb_cyc && wb_ack;

    // instr not loaded yet at the fetch ack, so look at the bus word
    assign need_operand =
        wb_dat_i[control_pkg::CTRL_HI:control_pkg::CTRL_LO] == control_pkg::OP_ROM_DIRECT;

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH: begin
                if (bus_done) begin
                    state_nxt = need_operand ? OPERAND : WRITE;
                end
            end
            OPERAND: begin
                if (bus_done) begin
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                state_nxt = (dec.targ_dev == control_pkg::TDEV_HALT) ? HALT : FETCH;
            end
            HALT: begin
                state_nxt = HALT; // only reset leaves
            end
            default: begin
                state_nxt = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= FETCH;
            wb_cyc <= 1'b0;
            pc     <= '0;
        end else begin
            state  <= state_nxt;
            wb_cyc <= (state_nxt == FETCH) || (state_nxt == OPERAND);
            if (write_en) begin
                if (dec.targ_dev == control_pkg::TDEV_PC) begin
                    pc <= {{(control_pkg::PC_WIDTH-alu_pkg::DATA_WIDTH){1'b0}}, alu_result};
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && bus_done) begin
            instr <= wb_dat_i;
        end
        if (state == OPERAND && bus_done) begin
            rom_operand <= wb_dat_i[alu_pkg::DATA_WIDTH-1:0]; // low byte only
        end
    end

    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0; // program memory is read-only
    assign wb_adr = (state == OPERAND) ? instr[control_pkg::PC_WIDTH-1:0] : pc;

    assign write_en  = (state == WRITE);
    assign out_data  = alu_result;
    assign out_valid = write_en && (dec.targ_dev == control_pkg::TDEV_OUT);
    assign halted    = (state == HALT);

endmodule : sequencer

//--- verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic clk,
    input  logic arst_n,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output logic [control_pkg::PC_WIDTH-1:0] wb_adr,
    input  logic [control_pkg::INSTR_WIDTH-1:0] wb_dat_i,
    input  logic wb_ack,
    output logic [alu_pkg::DATA_WIDTH-1:0] out_data,
    output logic out_valid,
    output logic halted
);

    logic [control_pkg::INSTR_WIDTH-1:0] instr;
    logic [alu_pkg::DATA_WIDTH-1:0] rom_operand;
    logic [alu_pkg::DATA_WIDTH-1:0] alu_result;
    logic write_en;

    decode_if dec_bus ();

    sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec         (dec_bus.control),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .alu_result  (alu_result),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .instr       (instr),
        .rom_operand (rom_operand),
        .write_en    (write_en),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halted      (halted)
    );

    op_decoder u_op_decoder (
        .instr (instr),
        .dec   (dec_bus.decoder)
    );

    device_bank u_device_bank (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec         (dec_bus.datapath),
        .instr       (instr),
        .rom_operand (rom_operand),
        .write_en    (write_en),
        .alu_result  (alu_result)
    );

endmodule : cpu_core

//--- verification/cpu_core_props.sv
`timescale 1ns/1ps

module cpu_core_props (
    input logic clk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic [control_pkg::PC_WIDTH-1:0] wb_adr,
    input logic wb_ack,
    input logic out_valid,
    input logic halted
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request steady through wait states
    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
        else $error("wishbone request changed before ack");

    out_pulse: assert property (@(posedge clk) disable iff (!arst_n) out_valid |=> !out_valid)
        else $error("out_valid high for two cycles");

    no_fetch_halted: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !wb_cyc)
        else $error("bus cycle while halted");

endmodule : cpu_core_props

bind cpu_core cpu_core_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack),
    .out_valid (out_valid),
    .halted    (halted)
);

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [control_pkg::PC_WIDTH-1:0] wb_adr;
    logic [control_pkg::INSTR_WIDTH-1:0] wb_dat_i = '0;
    logic wb_ack = 1'b0;
    logic [alu_pkg::DATA_WIDTH-1:0] out_data;
    logic out_valid;
    logic halted;

    logic [23:0] mem [65536];
    logic [23:0] prog [$];
    logic [7:0] outs [$];
    logic [7:0] exp_bytes [$];
    int wait_left;
    bit busy;
    int errors;
    int checks;

    cpu_core DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    always #50 clk = ~clk;

    // program memory, 0..3 wait states per access
    always @(posedge clk) begin
        if (!arst_n || wb_ack) begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem[wb_adr];
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && out_valid) outs.push_back(out_data);
    end

    // program port never writes
    always @(posedge clk) begin
        if (wb_we !== 1'b0) begin
            $display("ERROR %0t: wb_we is %b, expected 0", $time, wb_we);
            errors++;
        end
    end

    function automatic logic [23:0] alu_word(input logic [4:0] targ, input logic [3:0] l,
                                             input logic [3:0] r, input logic [4:0] op);
        return {control_pkg::OP_ALU, targ, 3'b000, l, r, op};
    endfunction

    function automatic logic [23:0] field_word(input logic [2:0] opc, input logic [4:0] targ,
                                               input logic [15:0] fld);
        return {opc, targ, fld};
    endfunction

    function automatic logic [23:0] const_word(input logic [4:0] targ, input logic [7:0] imm);
        return field_word(control_pkg::OP_CONST8, targ, {8'h00, imm});
    endfunction

    function automatic logic [23:0] emit_word(input logic [3:0] dev);
        return alu_word(control_pkg::TDEV_OUT, dev, control_pkg::DEV_ZERO, alu_pkg::ALUOP_PASSA);
    endfunction

    // expected result per operation table
    function automatic logic [7:0] alu_ref(input logic [4:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        case (op)
            5'd0: return a;
            5'd1: return b;
            5'd2: return a + b;
            5'd3: return a - b;
            5'd4: return a & b;
            5'd5: return a | b;
            5'd6: return a ^ b;
            5'd7: return ~a;
            5'd8: return {a[6:0], 1'b0};
            5'd9: return {1'b0, a[7:1]};
            default: return 8'h00;
        endcase
    endfunction

    task automatic load_program();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {control_pkg::OP_ALU, control_pkg::TDEV_HALT, 16'(a)}; // halt filler
        end
        foreach (prog[i]) mem[i] = prog[i];
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (5) @(posedge clk);
        outs.delete();
        arst_n <= 1'b1;
    endtask

    task automatic wait_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: CPU did not halt within %0d cycles", name, cycles);
            errors++;
        end else begin
            repeat (20) begin // quiet window after halt
                @(posedge clk);
                checks++;
                if (wb_cyc || out_valid) begin
                    $display("ERROR %0t: %s bus or output activity after halt", $time, name);
                    errors++;
                end
            end
        end
    endtask

    task automatic compare_outputs(input string name);
        checks++;
        if (outs.size() != exp_bytes.size()) begin
            $display("ERROR %0t: %s got %0d output bytes, expected %0d", $time, name,
                     outs.size(), exp_bytes.size());
            errors++;
        end
        foreach (exp_bytes[i]) begin
            checks++;
            if (i < outs.size() && outs[i] !== exp_bytes[i]) begin
                $display("ERROR %0t: %s byte %0d got %02h expected %02h", $time, name, i,
                         outs[i], exp_bytes[i]);
                errors++;
            end
        end
    endtask

    task automatic execute_program(input string name);
        pulse_reset();
        wait_halt(name);
        compare_outputs(name);
    endtask

    task automatic reset_and_first_fetch();
        int cycles;
        bit started;
        prog = {const_word(control_pkg::TDEV_REG_A, 8'h11), emit_word(control_pkg::DEV_REG_A)};
        exp_bytes = {8'h11};
        load_program();
        pulse_reset();
        cycles = 0;
        started = 1'b0;
        while (!(wb_cyc && wb_ack) && cycles < 100) begin
            @(posedge clk);
            cycles++;
            checks++;
            if (out_valid || halted || (started && !wb_cyc) || (wb_cyc && wb_adr != 16'h0)) begin
                $display("ERROR %0t: reset state wrong before first fetch ack", $time);
                errors++;
            end
            started = started | wb_cyc;
        end
        if (!(wb_cyc && wb_ack)) begin
            $display("reset test: first fetch was never acknowledged");
            errors++;
        end else begin
            @(posedge clk);
            checks++;
            if (wb_cyc) begin
                $display("ERROR %0t: wb_cyc still high in the cycle after ack", $time);
                errors++;
            end
        end
        wait_halt("reset");
        compare_outputs("reset");
    endtask

    task automatic constant_loads();
        prog = {const_word(control_pkg::TDEV_REG_A, 8'h3c),
                const_word(control_pkg::TDEV_REG_B, 8'ha5),
                const_word(control_pkg::TDEV_REG_C, 8'h01),
                const_word(control_pkg::TDEV_REG_D, 8'hff),
                emit_word(control_pkg::DEV_REG_B), emit_word(control_pkg::DEV_REG_A),
                emit_word(control_pkg::DEV_REG_D), emit_word(control_pkg::DEV_REG_C)};
        exp_bytes = {8'ha5, 8'h3c, 8'hff, 8'h01};
        load_program();
        execute_program("constant loads");
    endtask

    task automatic alu_operations();
        logic [7:0] a;
        logic [7:0] b;
        logic [4:0] op;
        prog = {};
        exp_bytes = {};
        for (int k = 0; k < 11; k++) begin
            op = (k < 10) ? 5'(k) : 5'(10 + $urandom_range(21, 0)); // last one unknown
            a = 8'($urandom);
            b = 8'($urandom);
            prog = {prog, const_word(control_pkg::TDEV_REG_C, a),
                    const_word(control_pkg::TDEV_REG_D, b),
                    alu_word(control_pkg::TDEV_OUT, control_pkg::DEV_REG_C,
                             control_pkg::DEV_REG_D, op)};
            exp_bytes = {exp_bytes, alu_ref(op, a, b)};
        end
        load_program();
        execute_program("alu operations");
    endtask

    task automatic ram_round_trip();
        prog = {const_word(control_pkg::TDEV_REG_A, 8'h5e),
                field_word(control_pkg::OP_STORE_RAM, {1'b0, control_pkg::DEV_REG_A}, 16'h0020),
                const_word(control_pkg::TDEV_REG_B, 8'h77),
                field_word(control_pkg::OP_STORE_RAM, {1'b0, control_pkg::DEV_REG_B}, 16'h0021),
                const_word(control_pkg::TDEV_REG_A, 8'h00),
                field_word(control_pkg::OP_RAM_DIRECT, control_pkg::TDEV_REG_C, 16'h0020),
                field_word(control_pkg::OP_RAM_DIRECT, control_pkg::TDEV_REG_D, 16'h0021),
                emit_word(control_pkg::DEV_REG_C), emit_word(control_pkg::DEV_REG_D)};
        exp_bytes = {8'h5e, 8'h77};
        load_program();
        execute_program("ram round trip");
    endtask

    task automatic rom_operand_and_nops();
        logic [23:0] rom_word;
        rom_word = 24'h3dc4b9;
        prog = {const_word(control_pkg::TDEV_REG_A, 8'h42),
                field_word(control_pkg::OP_ROM_DIRECT, control_pkg::TDEV_REG_B, 16'h8001),
                emit_word(control_pkg::DEV_REG_B),
                field_word(control_pkg::OP_NOP2, control_pkg::TDEV_OUT, 16'h1e4a),
                field_word(control_pkg::OP_NOP3, control_pkg::TDEV_REG_A, 16'h00c7),
                field_word(control_pkg::OP_NOP7, control_pkg::TDEV_REG_B, 16'h5a5a),
                emit_word(control_pkg::DEV_REG_A), emit_word(control_pkg::DEV_REG_B)};
        exp_bytes = {rom_word[7:0], 8'h42, rom_word[7:0]};
        load_program();
        mem[16'h8001] = rom_word;
        execute_program("rom operand and no-ops");
    endtask

    task automatic jump_and_halt();
        prog = {const_word(control_pkg::TDEV_REG_A, 8'h99),
                const_word(control_pkg::TDEV_PC, 8'h04), // skips words 2 and 3
                emit_word(control_pkg::DEV_REG_A), emit_word(control_pkg::DEV_REG_A),
                const_word(control_pkg::TDEV_REG_B, 8'h66),
                emit_word(control_pkg::DEV_REG_B),
                alu_word(control_pkg::TDEV_HALT, control_pkg::DEV_ZERO, control_pkg::DEV_ZERO,
                         alu_pkg::ALUOP_PASSA),
                emit_word(control_pkg::DEV_REG_A)};
        exp_bytes = {8'h66};
        load_program();
        execute_program("jump and halt");
    endtask

    initial begin
        errors = 0;
        checks = 0;
        void'($urandom(32'hf645_05a5));
        reset_and_first_fetch();
        constant_loads();
        alu_operations();
        ram_round_trip();
        rom_operand_and_nops();
        jump_and_halt();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : cpu_core_tb

//--- cpu_core.f
verilog/control_pkg.sv
verilog/alu_pkg.sv
verilog/decode_if.sv
verilog/op_decoder.sv
verilog/alu.sv
verilog/device_bank.sv
verilog/sequencer.sv
verilog/cpu_core.sv
verification/cpu_core_props.sv
verification/cpu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
